// ==== Makefile ====
TOP := tb_rf_top
RTL := logic/rf_pkg.sv logic/rf_port_if.sv logic/rf_rsp_if.sv logic/rf_sleep_ctrl.sv \
       logic/rf_cmd_issue.sv logic/rf_regs_ff.sv logic/rf_rsp_fifo.sv logic/rf_top.sv

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP)

build:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
	  --top-module $(TOP) -f all.f

lint:
	verilator --lint-only -Wall --top-module rf_top $(RTL)

clean:
	rm -rf obj_dir

// ==== all.f ====
logic/rf_pkg.sv
logic/rf_port_if.sv
logic/rf_rsp_if.sv
logic/rf_sleep_ctrl.sv
logic/rf_cmd_issue.sv
logic/rf_regs_ff.sv
logic/rf_rsp_fifo.sv
logic/rf_top.sv
test/tb_rf_top.sv

// ==== logic/rf_cmd_issue.sv ====
////////////////////
// Command issuer
// Accepts commands, drives the write port, pushes read results
////////////////////

`default_nettype none

module rf_cmd_issue import rf_pkg::*; (
  input  logic      awake_i,

  // Command stream
  input  logic      cmd_valid_i,
  output logic      cmd_ready_o,
  input  logic      cmd_we_i,
  input  reg_addr_t cmd_waddr_i,
  input  reg_data_t cmd_wdata_i,
  input  reg_addr_t cmd_raddr_a_i,
  input  reg_addr_t cmd_raddr_b_i,

  // Register array and response path
  rf_port_if.issuer port,
  rf_rsp_if.src     rsp
);

  logic accept;
  logic is_read;

  assign is_read = ~cmd_we_i;

  /////////////////////
  // Acceptance
  /////////////////////

  // Writes never need a FIFO slot, reads do
  assign cmd_ready_o = awake_i & (cmd_we_i | rsp.ready);
  assign accept      = cmd_valid_i & cmd_ready_o;

  /////////////////////
  // Write port
  /////////////////////

  assign port.we    = accept & cmd_we_i;
  assign port.waddr = cmd_waddr_i;
  assign port.wdata = cmd_wdata_i;

  /////////////////////
  // Read and push
  /////////////////////

  assign port.raddr_a = cmd_raddr_a_i;
  assign port.raddr_b = cmd_raddr_b_i;

  // Read data is combinational, so the pair enters the FIFO this cycle
  assign rsp.valid  = accept & is_read;
  assign rsp.data_a = port.rdata_a;
  assign rsp.data_b = port.rdata_b;

endmodule

`default_nettype wire

// ==== logic/rf_pkg.sv ====
////////////////////
// Shared widths, depths and vector types of the register file block
////////////////////

`default_nettype none

package rf_pkg;

  // Register file geometry
  localparam int DataW    = 32;
  localparam int NumRegs  = 32;
  localparam int RegAddrW = $clog2(NumRegs);

  // Response path
  localparam int RspDepth = 4;
  localparam int RspPtrW  = $clog2(RspDepth);

  // Register index
  typedef logic [RegAddrW-1:0] reg_addr_t;

  // One register value
  typedef logic [DataW-1:0] reg_data_t;

  // FIFO fill level, 0 to RspDepth inclusive
  typedef logic [RspPtrW:0] rsp_cnt_t;

endpackage

`default_nettype wire

// ==== logic/rf_port_if.sv ====
////////////////////
// Register array access port
// Two combinational reads, one write
////////////////////

`default_nettype none

interface rf_port_if import rf_pkg::*; ();

  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  reg_data_t rdata_a;
  reg_data_t rdata_b;
  reg_addr_t waddr;
  reg_data_t wdata;
  logic      we;

  modport issuer (
    output raddr_a, raddr_b, waddr, wdata, we,
    input  rdata_a, rdata_b
  );

  modport regs (
    input  raddr_a, raddr_b, waddr, wdata, we,
    output rdata_a, rdata_b
  );

endinterface

`default_nettype wire

// ==== logic/rf_regs_ff.sv ====
////////////////////
// Flip-flop register array
// Register 0 hardwired to zero
////////////////////

`default_nettype none

module rf_regs_ff import rf_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      en_i,
  rf_port_if.regs   port
);

  reg_data_t          rf_reg [NumRegs];
  logic [NumRegs-1:1] we_dec;

  // Write decode, gated by the clock enable
  always_comb begin
    for (int i = 1; i < NumRegs; i++) begin
      we_dec[i] = en_i & port.we & (port.waddr == reg_addr_t'(i));
    end
  end

  // Not stored, writes to it fall away in the decode
  assign rf_reg[0] = '0;

  for (genvar i = 1; i < NumRegs; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_reg[i] <= '0;
      end else if (we_dec[i]) begin
        rf_reg[i] <= port.wdata;
      end
    end
  end

  // Combinational reads
  assign port.rdata_a = rf_reg[port.raddr_a];
  assign port.rdata_b = rf_reg[port.raddr_b];

endmodule

`default_nettype wire

// ==== logic/rf_rsp_fifo.sv ====
////////////////////
// Response FIFO
// Circular buffer of read-data pairs with in-order output
////////////////////

`default_nettype none

module rf_rsp_fifo import rf_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Push side
  rf_rsp_if.dst     rsp,

  // Pop side
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output reg_data_t rsp_data_a_o,
  output reg_data_t rsp_data_b_o,

  output logic      pending_o
);

  reg_data_t          mem_a [RspDepth];
  reg_data_t          mem_b [RspDepth];
  logic [RspPtrW-1:0] wr_ptr_q;
  logic [RspPtrW-1:0] rd_ptr_q;
  rsp_cnt_t           cnt_q;
  logic               full;
  logic               empty;
  logic               push;
  logic               pop;

  assign full  = (cnt_q == rsp_cnt_t'(RspDepth));
  assign empty = (cnt_q == '0);

  // A full FIFO refuses a push even while it pops
  assign rsp.ready = ~full;
  assign push      = rsp.valid & rsp.ready;
  assign pop       = rsp_valid_o & rsp_ready_i;

  /////////////////////
  // Storage
  /////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_a[wr_ptr_q] <= rsp.data_a;
      mem_b[wr_ptr_q] <= rsp.data_b;
    end
  end

  /////////////////////
  // Pointers and count
  /////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + rsp_cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - rsp_cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Head entry, visible the cycle after its push
  assign rsp_valid_o  = ~empty;
  assign rsp_data_a_o = mem_a[rd_ptr_q];
  assign rsp_data_b_o = mem_b[rd_ptr_q];
  assign pending_o    = ~empty;

endmodule

`default_nettype wire

// ==== logic/rf_rsp_if.sv ====
////////////////////
// Read result handshake from the issuer into the response FIFO
////////////////////

`default_nettype none

interface rf_rsp_if import rf_pkg::*; ();

  logic      valid;
  logic      ready;
  reg_data_t data_a;
  reg_data_t data_b;

  // Producer side
  modport src (
    output valid, data_a, data_b,
    input  ready
  );

  // Buffer side, ready only while not full
  modport dst (
    input  valid, data_a, data_b,
    output ready
  );

endinterface

`default_nettype wire

// ==== logic/rf_sleep_ctrl.sv ====
////////////////////
// Wake and sleep control
// Fetch-enable latch, busy register and awake decision
////////////////////

`default_nettype none

module rf_sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic fetch_enable_i,
  input  logic cmd_valid_i,
  input  logic rsp_pending_i,
  input  logic irq_i,
  input  logic debug_req_i,
  output logic awake_o
);

  logic fetch_en_q;
  logic busy_d;
  logic busy_q;

  // Work outstanding, either a new command or an undrained response
  assign busy_d = cmd_valid_i | rsp_pending_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= busy_d;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_en_q <= 1'b1;
    end
  end

  // Wake inputs act in the same cycle, busy one edge later
  assign awake_o = fetch_en_q & (busy_q | debug_req_i | irq_i);

endmodule

`default_nettype wire

// ==== logic/rf_top.sv ====
////////////////////
// Register file block top level
// Sleep control, command issuer, register array and response FIFO
////////////////////

`default_nettype none

module rf_top import rf_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Control
  input  logic      fetch_enable_i,
  input  logic      irq_i,
  input  logic      debug_req_i,
  output logic      core_sleep_o,

  // Command stream
  input  logic      cmd_valid_i,
  output logic      cmd_ready_o,
  input  logic      cmd_we_i,
  input  reg_addr_t cmd_waddr_i,
  input  reg_data_t cmd_wdata_i,
  input  reg_addr_t cmd_raddr_a_i,
  input  reg_addr_t cmd_raddr_b_i,

  // Response stream
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output reg_data_t rsp_data_a_o,
  output reg_data_t rsp_data_b_o
);

  logic awake;
  logic rsp_pending;

  rf_port_if port_bus ();
  rf_rsp_if  rsp_bus ();

  /////////////////////
  // Sleep control
  /////////////////////

  rf_sleep_ctrl u_sleep_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .cmd_valid_i    (cmd_valid_i),
    .rsp_pending_i  (rsp_pending),
    .irq_i          (irq_i),
    .debug_req_i    (debug_req_i),
    .awake_o        (awake)
  );

  assign core_sleep_o = ~awake;

  /////////////////////
  // Command issue
  /////////////////////

  rf_cmd_issue u_cmd_issue (
    .awake_i       (awake),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_we_i      (cmd_we_i),
    .cmd_waddr_i   (cmd_waddr_i),
    .cmd_wdata_i   (cmd_wdata_i),
    .cmd_raddr_a_i (cmd_raddr_a_i),
    .cmd_raddr_b_i (cmd_raddr_b_i),
    .port          (port_bus),
    .rsp           (rsp_bus)
  );

  /////////////////////
  // Register array
  /////////////////////

  // Awake acts as the clock enable
  rf_regs_ff u_regs (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (awake),
    .port   (port_bus)
  );

  /////////////////////
  // Response FIFO
  /////////////////////

  // Free running so responses drain during sleep
  rf_rsp_fifo u_rsp_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rsp          (rsp_bus),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_data_a_o (rsp_data_a_o),
    .rsp_data_b_o (rsp_data_b_o),
    .pending_o    (rsp_pending)
  );

endmodule

`default_nettype wire

// ==== test/tb_rf_top.sv ====
////////////////////
// Testbench for the register file block
// Reference model, concurrent checks, directed and random stimulus
////////////////////

`default_nettype none

module tb_rf_top import rf_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkPeriod      = 20;
  localparam int DriveDelay     = 2;
  localparam int ResetCycles    = 8;
  localparam int RandSeed       = 38;
  localparam int DirectedCmds   = 26;
  localparam int RandCmds       = 300;
  localparam int WatchdogCycles = 20 * (DirectedCmds + RandCmds) + 200;

  logic      clk_i;
  logic      rst_ni;
  logic      fetch_enable_i;
  logic      irq_i;
  logic      debug_req_i;
  logic      core_sleep_o;
  logic      cmd_valid_i;
  logic      cmd_ready_o;
  logic      cmd_we_i;
  reg_addr_t cmd_waddr_i;
  reg_data_t cmd_wdata_i;
  reg_addr_t cmd_raddr_a_i;
  reg_addr_t cmd_raddr_b_i;
  logic      rsp_valid_o;
  logic      rsp_ready_i;
  reg_data_t rsp_data_a_o;
  reg_data_t rsp_data_b_o;

  // Reference model state
  reg_data_t   ref_regs [NumRegs];
  logic [63:0] exp_q [$];
  logic        fetch_q;
  logic        busy_q;
  int          exp_cnt;
  reg_data_t   exp_head_a;
  reg_data_t   exp_head_b;
  logic        exp_awake;
  logic        exp_ready;
  logic        exp_accept;

  string       test_name;
  logic        random_stall;

  rf_top UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .irq_i          (irq_i),
    .debug_req_i    (debug_req_i),
    .core_sleep_o   (core_sleep_o),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .cmd_we_i       (cmd_we_i),
    .cmd_waddr_i    (cmd_waddr_i),
    .cmd_wdata_i    (cmd_wdata_i),
    .cmd_raddr_a_i  (cmd_raddr_a_i),
    .cmd_raddr_b_i  (cmd_raddr_b_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_data_a_o   (rsp_data_a_o),
    .rsp_data_b_o   (rsp_data_b_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // Reference model
  ////////////////////

  assign exp_awake  = fetch_q & (busy_q | irq_i | debug_req_i);
  assign exp_ready  = exp_awake & (cmd_we_i | (exp_cnt < RspDepth));
  assign exp_accept = cmd_valid_i & exp_ready;

  always @(posedge clk_i or negedge rst_ni) begin
    logic [63:0] pair;
    if (!rst_ni) begin
      fetch_q    <= 1'b0;
      busy_q     <= 1'b0;
      exp_cnt    <= 0;
      exp_head_a <= '0;
      exp_head_b <= '0;
      exp_q.delete();
      for (int i = 0; i < NumRegs; i++) begin
        ref_regs[i] <= '0;
      end
    end else begin
      pair = {ref_regs[cmd_raddr_a_i], ref_regs[cmd_raddr_b_i]};
      // Register 0 keeps reading zero
      if (exp_accept && cmd_we_i && cmd_waddr_i != '0) begin
        ref_regs[cmd_waddr_i] <= cmd_wdata_i;
      end
      if (exp_q.size() != 0 && rsp_ready_i) begin
        void'(exp_q.pop_front());
      end
      if (exp_accept && !cmd_we_i) begin
        exp_q.push_back(pair);
      end
      busy_q <= cmd_valid_i | (exp_cnt != 0);
      if (fetch_enable_i) begin
        fetch_q <= 1'b1;
      end
      exp_cnt <= exp_q.size();
      if (exp_q.size() != 0) begin
        exp_head_a <= exp_q[0][63:32];
        exp_head_b <= exp_q[0][31:0];
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped after a failed check");
  endtask

  task automatic report_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
    $display("ERROR test %s, %s: expected %h, actual %h", test_name, what, expected, actual);
    abort_run();
  endtask

  a_sleep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o == !exp_awake)
    else report_value("core_sleep_o", 32'(!$sampled(exp_awake)), 32'($sampled(core_sleep_o)));

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_ready_o == exp_ready)
    else report_value("cmd_ready_o", 32'($sampled(exp_ready)), 32'($sampled(cmd_ready_o)));

  a_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o == (exp_cnt != 0))
    else report_value("rsp_valid_o", 32'($sampled(exp_cnt) != 0), 32'($sampled(rsp_valid_o)));

  a_data_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (exp_cnt != 0) |-> rsp_data_a_o == exp_head_a)
    else report_value("rsp_data_a_o", $sampled(exp_head_a), $sampled(rsp_data_a_o));

  a_data_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (exp_cnt != 0) |-> rsp_data_b_o == exp_head_b)
    else report_value("rsp_data_b_o", $sampled(exp_head_b), $sampled(rsp_data_b_o));

  // Read into an empty FIFO shows up one cycle later
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (exp_accept && !cmd_we_i && exp_cnt == 0) |=> rsp_valid_o)
    else report_value("rsp_valid_o after read", 32'd1, 32'($sampled(rsp_valid_o)));

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
    abort_run();
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #DriveDelay;
    if (random_stall) begin
      rsp_ready_i = ($urandom_range(3) != 0);
    end
  endtask

  task automatic drive_cmd(input logic we, input reg_addr_t waddr, input reg_data_t wdata,
                           input reg_addr_t raddr_a, input reg_addr_t raddr_b);
    cmd_valid_i   = 1'b1;
    cmd_we_i      = we;
    cmd_waddr_i   = waddr;
    cmd_wdata_i   = wdata;
    cmd_raddr_a_i = raddr_a;
    cmd_raddr_b_i = raddr_b;
  endtask

  // Handshake sampled mid-cycle, where outputs are settled
  task automatic wait_accept();
    logic taken;
    do begin
      @(negedge clk_i);
      taken = cmd_valid_i & cmd_ready_o;
      next_cycle();
    end while (!taken);
    cmd_valid_i = 1'b0;
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    drive_cmd(1'b1, addr, data, reg_addr_t'($urandom_range(NumRegs - 1)), '0);
    wait_accept();
  endtask

  // Write fields carry junk so a read that writes would show
  task automatic read_regs(input reg_addr_t addr_a, input reg_addr_t addr_b);
    drive_cmd(1'b0, reg_addr_t'($urandom_range(NumRegs - 1)), $urandom(), addr_a, addr_b);
    wait_accept();
  endtask

  task automatic wait_drain();
    while (rsp_valid_o) begin
      next_cycle();
    end
  endtask

  task automatic run_random_mix();
    logic we;
    for (int n = 0; n < RandCmds; n++) begin
      we = 1'($urandom_range(1));
      if ($urandom_range(3) == 0) begin
        next_cycle();
      end
      if (we) begin
        write_reg(reg_addr_t'($urandom_range(NumRegs - 1)), $urandom());
      end else begin
        read_regs(reg_addr_t'($urandom_range(NumRegs - 1)),
                  reg_addr_t'($urandom_range(NumRegs - 1)));
      end
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    void'($urandom(RandSeed));
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    irq_i          = 1'b0;
    debug_req_i    = 1'b0;
    cmd_valid_i    = 1'b0;
    cmd_we_i       = 1'b0;
    cmd_waddr_i    = '0;
    cmd_wdata_i    = '0;
    cmd_raddr_a_i  = '0;
    cmd_raddr_b_i  = '0;
    rsp_ready_i    = 1'b1;
    random_stall   = 1'b0;
    test_name      = "reset";
    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;

    // Held command stays blocked until fetch enable
    test_name = "reset_fetch";
    drive_cmd(1'b1, 5'd1, 32'h1111_0001, '0, '0);
    repeat (4) next_cycle();
    fetch_enable_i = 1'b1;
    next_cycle();
    fetch_enable_i = 1'b0;
    wait_accept();

    test_name = "write_read";
    for (int i = 1; i <= 8; i++) begin
      write_reg(reg_addr_t'(i), $urandom());
    end
    write_reg(5'd0, 32'hdead_beef);
    read_regs(5'd1, 5'd2);
    read_regs(5'd3, 5'd4);
    read_regs(5'd5, 5'd6);
    read_regs(5'd7, 5'd8);
    read_regs(5'd0, 5'd1);
    read_regs(5'd8, 5'd0);
    wait_drain();

    test_name = "latency";
    read_regs(5'd2, 5'd7);
    wait_drain();

    // Fill the FIFO, a fifth read stalls but a write goes through
    test_name = "backpressure";
    rsp_ready_i = 1'b0;
    for (int i = 0; i < RspDepth; i++) begin
      read_regs(reg_addr_t'(i + 3), reg_addr_t'(i + 1));
    end
    drive_cmd(1'b0, '0, '0, 5'd4, 5'd5);
    repeat (3) next_cycle();
    write_reg(5'd10, 32'h0a0a_5050);
    rsp_ready_i = 1'b1;
    wait_drain();

    test_name = "sleep_wake";
    repeat (4) next_cycle();
    irq_i = 1'b1;
    repeat (2) next_cycle();
    irq_i = 1'b0;
    repeat (3) next_cycle();
    debug_req_i = 1'b1;
    write_reg(5'd9, 32'h0909_0909);
    debug_req_i = 1'b0;
    read_regs(5'd9, 5'd10);
    wait_drain();
    repeat (3) next_cycle();

    test_name = "random_mix";
    random_stall = 1'b1;
    run_random_mix();
    random_stall = 1'b0;
    rsp_ready_i  = 1'b1;
    wait_drain();
    repeat (2) next_cycle();

    if (exp_q.size() != 0) begin
      $display("Responses left in the reference queue at the end: %0d", exp_q.size());
      abort_run();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire
